//--- filelist.f
+incdir+src
src/bus_pkg.sv
src/mem_map_pkg.sv
src/bus_ctrl.sv
src/ram_bank.sv
src/read_return.sv
src/key_irq.sv
src/soc_bus_top.sv
verif/tb_soc_bus.sv

//--- Makefile
# Verilator build and run of the bus fabric testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module tb_soc_bus -f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_soc_bus | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_soc_bus.sv
`include "soc_config.svh"

module tb_soc_bus;
    import bus_pkg::*;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [63:0] dat_w;
    ls_type_e    ls_type;
    logic [63:0] dat_r;
    logic        ack;
    logic        key_valid;
    logic [7:0]  key_ascii;
    logic        irq;
    logic        irq_ack;
    logic        uart_valid;
    logic [7:0]  uart_data;

    logic [7:0] ref_mem [0:4095];  // byte image of the ram
    integer     seed = 32'h807c;
    int         errors = 0;
    int         checks = 0;
    int         err_base = 0;
    int         uart_pulses = 0;
    logic [7:0] uart_last;

    soc_bus_top DUT (.*);

    always #10 CLOCK_50 = ~CLOCK_50;

    // uart strobe monitor
    always @(posedge CLOCK_50) begin
        if (uart_valid) begin
            uart_pulses <= uart_pulses + 1;
            uart_last   <= uart_data;
        end
    end

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %0t: %s returned %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic flag_timeout(input string what);
        $display("timeout: no response for %s within 20 cycles", what);
        errors++;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // registers and unmapped take 1 cycle, ram 2 and a ram double 3
    function automatic int expected_latency(input logic [31:0] a, input ls_type_e t);
        if (a >= `SOC_RAM_WORDS * 4) return 1;
        return (t == LS_D) ? 3 : 2;
    endfunction

    task automatic store_ref(input logic [31:0] a, input ls_type_e t, input logic [63:0] d);
        logic [63:0] v;
        v = d;
        for (int i = 0; i < (1 << t[1:0]); i++) begin
            ref_mem[a[11:0] + 12'(i)] = v[7:0];  // little endian
            v = v >> 8;
        end
    endtask

    function automatic logic [63:0] load_ref(input logic [31:0] a, input ls_type_e t);
        logic [63:0] v;
        v = '0;
        for (int i = (1 << t[1:0]) - 1; i >= 0; i--) begin
            v = {v[55:0], ref_mem[a[11:0] + 12'(i)]};
        end
        case (t)
            LS_B:    v = {{56{v[7]}}, v[7:0]};
            LS_H:    v = {{48{v[15]}}, v[15:0]};
            LS_W:    v = {{32{v[31]}}, v[31:0]};
            default: ;  // unsigned and double are zero filled already
        endcase
        return v;
    endfunction

    task automatic transfer(input logic [31:0] a, input logic w, input ls_type_e t,
                            input logic [63:0] d, output logic [63:0] q, output int lat);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        @(posedge CLOCK_50);
        cyc     <= 1'b1;
        stb     <= 1'b1;
        we      <= w;
        adr     <= a;
        ls_type <= t;
        dat_w   <= d;
        while (!seen && n < 20) begin
            @(posedge CLOCK_50);
            n++;
            seen = ack;
            q = dat_r;  // dat_r is valid alongside ack
        end
        if (!seen) begin
            flag_timeout("a bus transfer");
        end
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        lat = n - 1;  // first edge only samples the request
    endtask

    task automatic bus_write(input logic [31:0] a, input ls_type_e t, input logic [63:0] d);
        logic [63:0] q;
        int          lat;
        transfer(a, 1'b1, t, d, q, lat);
        if (a < `SOC_RAM_WORDS * 4) store_ref(a, t, d);
        expect_equal("write latency", 64'(lat), 64'(expected_latency(a, t)));
    endtask

    task automatic bus_read(input logic [31:0] a, input ls_type_e t, input logic [63:0] exp,
                            input string what);
        logic [63:0] q;
        int          lat;
        transfer(a, 1'b0, t, 64'd0, q, lat);
        expect_equal(what, q, exp);
        expect_equal({what, " latency"}, 64'(lat), 64'(expected_latency(a, t)));
    endtask

    task automatic wait_irq(input logic level, input string what);
        int n;
        n = 0;
        while (irq !== level && n < 20) begin
            @(posedge CLOCK_50);
            n++;
        end
        if (irq !== level) flag_timeout(what);
    endtask

    task automatic pulse_key(input logic [7:0] code);
        @(posedge CLOCK_50);
        key_valid <= 1'b1;
        key_ascii <= code;
        @(posedge CLOCK_50);
        key_valid <= 1'b0;
    endtask

    task automatic word_double_round_trip();
        logic [31:0] a;
        logic [63:0] d;
        for (int i = 0; i < 4; i++) begin
            a = $random(seed) & 32'h0000_0ff0;  // leaves room for the double at a + 8
            d = rand64();
            bus_write(a, LS_W, d);
            bus_read(a, LS_W, {{32{d[31]}}, d[31:0]}, "word read");
            bus_write(a + 32'd8, LS_D, d);
            bus_read(a + 32'd8, LS_D, d, "double read");
        end
        report_test("word and double round trip");
    endtask

    task automatic byte_half_lanes();
        logic [31:0] a;
        a = 32'h0000_0200;
        bus_write(a, LS_W, 64'h0000_0000_a5a5_a5a5);
        for (int i = 0; i < 4; i++) begin
            bus_write(a + 32'(i), LS_B, rand64());  // upper bits must not leak
            bus_read(a, LS_WU, load_ref(a, LS_WU), "word after byte store");
        end
        for (int j = 0; j < 2; j++) begin
            bus_write(a + 32'(2 * j), LS_H, rand64());
            bus_read(a, LS_WU, load_ref(a, LS_WU), "word after half store");
        end
        report_test("byte and half lanes");
    endtask

    task automatic sign_extension();
        bus_write(32'h300, LS_W, 64'h0000_0000_8001_7f80);
        bus_write(32'h304, LS_W, 64'd0);
        bus_write(32'h304, LS_H, 64'h8001);
        bus_write(32'h306, LS_B, 64'h80);
        bus_read(32'h306, LS_B,  64'hffff_ffff_ffff_ff80, "lb");
        bus_read(32'h306, LS_BU, 64'h0000_0000_0000_0080, "lbu");
        bus_read(32'h304, LS_H,  64'hffff_ffff_ffff_8001, "lh");
        bus_read(32'h304, LS_HU, 64'h0000_0000_0000_8001, "lhu");
        bus_read(32'h300, LS_H,  64'h0000_0000_0000_7f80, "lh positive");
        bus_read(32'h300, LS_W,  64'hffff_ffff_8001_7f80, "lw");
        bus_read(32'h300, LS_WU, 64'h0000_0000_8001_7f80, "lwu");
        report_test("sign and zero extension");
    endtask

    task automatic keyboard_irq();
        pulse_key(8'h41);
        wait_irq(1'b1, "irq after a key press");
        bus_read(`SOC_KEY_ADDR, LS_BU, 64'h41, "key register");
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        wait_irq(1'b0, "irq clear after irq_ack");
        pulse_key(8'h00);
        repeat (3) @(posedge CLOCK_50);  // irq would be up one cycle after the pulse
        expect_equal("irq on zero code", {63'd0, irq}, 64'd0);
        bus_read(`SOC_KEY_ADDR, LS_BU, 64'd0, "key register after zero code");
        report_test("keyboard and interrupt");
    endtask

    task automatic uart_and_unmapped();
        int base;
        base = uart_pulses;
        bus_write(`SOC_UART_ADDR, LS_B, 64'h1234_5678_9abc_de5a);
        repeat (3) @(posedge CLOCK_50);
        expect_equal("uart pulse count", 64'(uart_pulses - base), 64'd1);
        expect_equal("uart byte", {56'd0, uart_last}, 64'h5a);
        bus_read(32'h0000_8000, LS_D, 64'd0, "unmapped read");
        report_test("uart and unmapped");
    endtask

    initial begin
        KEY0      <= 1'b0;
        cyc       <= 1'b0;
        stb       <= 1'b0;
        we        <= 1'b0;
        adr       <= 32'd0;
        dat_w     <= 64'd0;
        ls_type   <= LS_B;
        key_valid <= 1'b0;
        key_ascii <= 8'd0;
        irq_ack   <= 1'b0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        word_double_round_trip();
        byte_half_lanes();
        sign_extension();
        keyboard_irq();
        uart_and_unmapped();
        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src/soc_bus_top.sv
`include "soc_config.svh"

module soc_bus_top (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    // wishbone classic slave
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`SOC_ADDR_W-1:0] adr,
    input  logic [`SOC_DATA_W-1:0] dat_w,
    input  bus_pkg::ls_type_e      ls_type,
    output logic [`SOC_DATA_W-1:0] dat_r,
    output logic                   ack,
    // keyboard
    input  logic                   key_valid,
    input  logic [7:0]             key_ascii,
    output logic                   irq,
    input  logic                   irq_ack,
    // uart tx
    output logic                   uart_valid,
    output logic [7:0]             uart_data
);

    logic        ram_en;
    logic        ram_we;
    logic        ram_hi;
    logic [9:0]  ram_word;
    logic        lo_capture;
    logic        src_key;
    logic [31:0] rdata;
    logic [7:0]  key_code;

    assign uart_data = dat_w[7:0];

    bus_ctrl u_ctrl (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .ls_type    (ls_type),
        .ack        (ack),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_hi     (ram_hi),
        .ram_word   (ram_word),
        .lo_capture (lo_capture),
        .src_key    (src_key),
        .uart_valid (uart_valid)
    );

    ram_bank u_ram (
        .CLOCK_50 (CLOCK_50),
        .ram_en   (ram_en),
        .ram_we   (ram_we),
        .ram_hi   (ram_hi),
        .ram_word (ram_word),
        .offset   (adr[1:0]),
        .ls_type  (ls_type),
        .dat_w    (dat_w),
        .rdata    (rdata)
    );

    read_return u_ret (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .rdata      (rdata),
        .lo_capture (lo_capture),
        .src_key    (src_key),
        .ls_type    (ls_type),
        .offset     (adr[1:0]),
        .key_code   (key_code),
        .dat_r      (dat_r)
    );

    key_irq u_key (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_valid (key_valid),
        .key_ascii (key_ascii),
        .irq_ack   (irq_ack),
        .key_code  (key_code),
        .irq       (irq)
    );

endmodule

//--- src/key_irq.sv
module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       irq_ack,
    output logic [7:0] key_code,
    output logic       irq
);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code <= 8'd0;
            irq      <= 1'b0;
        end else begin
            if (key_valid) begin
                key_code <= key_ascii;  // zero codes latch too
            end
            // a fresh key beats a pending ack
            if (key_valid && (key_ascii != 8'd0)) begin
                irq <= 1'b1;
            end else if (irq && irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

//--- src/read_return.sv
module read_return (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [31:0]       rdata,
    input  logic              lo_capture,
    input  logic              src_key,
    input  bus_pkg::ls_type_e ls_type,
    input  logic [1:0]        offset,
    input  logic [7:0]        key_code,
    output logic [63:0]       dat_r
);
    import bus_pkg::*;

    logic [31:0] lo_q;     // low word of a double read
    logic [31:0] shifted;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            lo_q <= 32'd0;
        end else begin
            lo_q <= lo_capture ? rdata : 32'd0;
        end
    end

    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        if (src_key) begin
            dat_r = {56'd0, key_code};
        end else begin
            case (ls_type)
                LS_B:    dat_r = {{56{shifted[7]}}, shifted[7:0]};
                LS_H:    dat_r = {{48{shifted[15]}}, shifted[15:0]};
                LS_W:    dat_r = {{32{shifted[31]}}, shifted};
                LS_D:    dat_r = {rdata, lo_q};  // high word just came back
                LS_BU:   dat_r = {56'd0, shifted[7:0]};
                LS_HU:   dat_r = {48'd0, shifted[15:0]};
                default: dat_r = {32'd0, shifted};
            endcase
        end
    end

endmodule

//--- src/ram_bank.sv
`include "soc_config.svh"

module ram_bank (
    input  logic              CLOCK_50,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic              ram_hi,
    input  logic [9:0]        ram_word,
    input  logic [1:0]        offset,
    input  bus_pkg::ls_type_e ls_type,
    input  logic [63:0]       dat_w,
    output logic [31:0]       rdata
);

    logic [31:0] mem [0:`SOC_RAM_WORDS-1];
    logic [31:0] src;
    logic [31:0] wdata;
    logic [3:0]  lane_en;

    assign src = ram_hi ? dat_w[63:32] : dat_w[31:0];

    // replicate the store data, then pick lanes by size and offset
    always_comb begin
        case (ls_type[1:0])
            2'd0: begin
                wdata   = {4{src[7:0]}};
                lane_en = 4'b0001 << offset;
            end
            2'd1: begin
                wdata   = {2{src[15:0]}};
                lane_en = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata   = src;  // word or one half of a double
                lane_en = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_en && ram_we) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) mem[ram_word][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        // output reg reads zero when not reading
        rdata <= (ram_en && !ram_we) ? mem[ram_word] : 32'd0;
    end

endmodule

//--- src/bus_ctrl.sv
`include "soc_config.svh"

module bus_ctrl (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`SOC_ADDR_W-1:0] adr,
    input  bus_pkg::ls_type_e      ls_type,
    output logic                   ack,
    output logic                   ram_en,
    output logic                   ram_we,
    output logic                   ram_hi,
    output logic [9:0]             ram_word,
    output logic                   lo_capture,
    output logic                   src_key,
    output logic                   uart_valid
);
    import bus_pkg::*;
    import mem_map_pkg::*;

    ctrl_state_e state;
    region_e     rgn;

    assign rgn = decode_region(adr);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= IDLE;
            ack        <= 1'b0;
            ram_en     <= 1'b0;
            ram_we     <= 1'b0;
            ram_hi     <= 1'b0;
            ram_word   <= '0;
            lo_capture <= 1'b0;
            src_key    <= 1'b0;
            uart_valid <= 1'b0;
        end else begin
            ack        <= 1'b0;  // single-cycle pulses by default
            uart_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (cyc && stb) begin
                        case (rgn)
                            REG_RAM: begin
                                ram_en   <= 1'b1;
                                ram_we   <= we;
                                ram_hi   <= 1'b0;
                                ram_word <= adr[11:2];
                                state    <= RAM_WAIT;
                            end
                            REG_KEY: begin
                                src_key <= !we;  // writes to the key reg are ignored
                                ack     <= 1'b1;
                                state   <= ACK_OUT;
                            end
                            REG_UART: begin
                                uart_valid <= we;  // lines up with ack
                                ack        <= 1'b1;
                                state      <= ACK_OUT;
                            end
                            default: begin
                                ack   <= 1'b1;  // unmapped reads return zero
                                state <= ACK_OUT;
                            end
                        endcase
                    end
                end
                RAM_WAIT: begin
                    if (ls_type == LS_D) begin
                        // upper word follows the low one
                        ram_hi     <= 1'b1;
                        ram_word   <= ram_word + 10'd1;
                        lo_capture <= !ram_we;
                        state      <= RAM_HI;
                    end else begin
                        ram_en <= 1'b0;
                        ram_we <= 1'b0;
                        ack    <= 1'b1;
                        state  <= ACK_OUT;
                    end
                end
                RAM_HI: begin
                    ram_en     <= 1'b0;
                    ram_we     <= 1'b0;
                    ram_hi     <= 1'b0;
                    lo_capture <= 1'b0;
                    ack        <= 1'b1;
                    state      <= ACK_OUT;
                end
                ACK_OUT: begin
                    // master drops stb here so no restart this edge
                    src_key <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- src/mem_map_pkg.sv
`include "soc_config.svh"

package mem_map_pkg;

    typedef enum logic [1:0] {
        REG_RAM  = 2'd0,
        REG_KEY  = 2'd1,
        REG_UART = 2'd2,
        REG_NONE = 2'd3
    } region_e;

    // anything outside the map decodes to REG_NONE
    function automatic region_e decode_region(input logic [`SOC_ADDR_W-1:0] addr);
        region_e rgn;
        if (addr < (`SOC_RAM_WORDS * 4)) begin
            rgn = REG_RAM;
        end else if (addr == `SOC_KEY_ADDR) begin
            rgn = REG_KEY;
        end else if (addr == `SOC_UART_ADDR) begin
            rgn = REG_UART;
        end else begin
            rgn = REG_NONE;
        end
        return rgn;
    endfunction

endpackage

//--- src/bus_pkg.sv
package bus_pkg;

    // load/store type as carried on the bus address tag
    // stores take the access size from bits 1:0
    typedef enum logic [2:0] {
        LS_B  = 3'd0,  // lb / sb
        LS_H  = 3'd1,  // lh / sh
        LS_W  = 3'd2,  // lw / sw
        LS_D  = 3'd3,  // ld / sd over two ram words
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // transfer sequencer
    typedef enum logic [1:0] {
        IDLE     = 2'd0,  // waiting for cyc & stb
        RAM_WAIT = 2'd1,  // first ram word in flight
        RAM_HI   = 2'd2,  // second word of a double
        ACK_OUT  = 2'd3   // ack is high this cycle
    } ctrl_state_e;

endpackage

//--- src/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64

// on-chip ram depth in 32-bit words
// 1024 words cover 0x0000_0000 .. 0x0000_0FFF
`define SOC_RAM_WORDS 1024

// register map
`define SOC_KEY_ADDR  32'h0000_F000  // read-only ascii code of the last key
`define SOC_UART_ADDR 32'h0000_F008  // write-only tx byte

`endif
